//--- hw/debug_pkg.sv
package debug_pkg;

    localparam int DATA_W            = 32;
    localparam int BYTE_W            = 8;
    localparam int BYTES_PER_WORD    = 4;
    localparam int IMEM_DEPTH        = 64;
    localparam int IMEM_ADDR_W       = $clog2(IMEM_DEPTH);
    localparam int DMEM_ADDR_W       = 6;
    localparam int TICK_DIV          = 2;   // Clocks per oversampling tick
    localparam int OVERSAMPLE        = 16;  // Ticks per serial bit
    localparam int STEP_CYCLES       = 3;
    localparam int PROG_RESET_CYCLES = 16;

    localparam int TICK_W = $clog2(TICK_DIV);
    localparam int OS_W   = $clog2(OVERSAMPLE);
    localparam int BIT_W  = $clog2(BYTE_W);
    localparam int BIDX_W = $clog2(BYTES_PER_WORD);
    localparam int STEP_W = $clog2(STEP_CYCLES + 1);
    localparam int PRST_W = $clog2(PROG_RESET_CYCLES + 1);

    localparam logic [BYTE_W-1:0] ACK_BYTE = 8'h52;  // 'R'

    localparam logic [BYTE_W-1:0] CMD_LOAD      = 8'h07;
    localparam logic [BYTE_W-1:0] CMD_RUN       = 8'h08;
    localparam logic [BYTE_W-1:0] CMD_STEP_MODE = 8'h09;
    localparam logic [BYTE_W-1:0] CMD_STEP      = 8'h0A;
    localparam logic [BYTE_W-1:0] CMD_DMEM_READ = 8'h0B;
    localparam logic [BYTE_W-1:0] CMD_PC_DUMP   = 8'h11;

    typedef struct packed {
        logic              valid;
        logic [BYTE_W-1:0] data;
    } rx_byte_t;

    typedef struct packed {
        logic              start;
        logic [BYTE_W-1:0] data;
    } tx_req_t;

    typedef struct packed {
        logic                   wr;
        logic [IMEM_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]      data;
    } imem_wr_t;

    typedef struct packed {
        logic set_run;
        logic set_step_mode;
        logic step;
        logic load_done;
    } run_cmd_t;

endpackage

//--- hw/uart_rx.sv
`timescale 1ns/100ps

module uart_rx import debug_pkg::*; (
    input  logic     i_clk,
    input  logic     i_reset,
    input  logic     i_tick,
    input  logic     i_rx,
    output rx_byte_t o_byte
);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t         state;
    logic [1:0]        sync;
    logic              rx_s;
    logic [OS_W-1:0]   s_cnt;
    logic [BIT_W-1:0]  bit_cnt;
    logic [BYTE_W-1:0] shreg;
    logic              valid;
    logic              half_end;
    logic              bit_end;

    assign rx_s     = sync[1];
    assign half_end = i_tick && (s_cnt == OS_W'(OVERSAMPLE / 2 - 1));
    assign bit_end  = i_tick && (s_cnt == OS_W'(OVERSAMPLE - 1));

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state   <= RX_IDLE;
            sync    <= 2'b11;  // Line idles high
            s_cnt   <= '0;
            bit_cnt <= '0;
            valid   <= 1'b0;
        end else begin
            sync  <= {sync[0], i_rx};
            valid <= 1'b0;
            if (state != RX_IDLE && i_tick) begin
                s_cnt <= (bit_end || (state == RX_START && half_end)) ? '0 : s_cnt + 1'b1;
            end
            case (state)
                RX_IDLE: begin
                    s_cnt <= '0;
                    if (!rx_s) state <= RX_START;
                end
                RX_START: begin
                    if (half_end) begin
                        bit_cnt <= '0;
                        state   <= rx_s ? RX_IDLE : RX_DATA;  // Reject short glitches
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BIT_W'(BYTE_W - 1)) state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        valid <= rx_s;  // Framing error drops the byte
                        state <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == RX_DATA && bit_end) shreg <= {rx_s, shreg[BYTE_W-1:1]};  // LSB first
    end

    assign o_byte = '{valid: valid, data: shreg};

    a_single_strobe: assert property (@(posedge i_clk) disable iff (i_reset)
        o_byte.valid |=> !o_byte.valid);

endmodule

//--- hw/uart_tx.sv
`timescale 1ns/100ps

module uart_tx import debug_pkg::*; (
    input  logic    i_clk,
    input  logic    i_reset,
    input  logic    i_tick,
    input  tx_req_t i_req,
    output logic    o_tx,
    output logic    o_busy
);

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

    tx_state_t         state;
    logic [OS_W-1:0]   s_cnt;
    logic [BIT_W-1:0]  bit_cnt;
    logic [BYTE_W-1:0] shreg;
    logic              bit_end;

    assign bit_end = i_tick && (s_cnt == OS_W'(OVERSAMPLE - 1));

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state   <= TX_IDLE;
            s_cnt   <= '0;
            bit_cnt <= '0;
        end else begin
            if (i_tick) s_cnt <= bit_end ? '0 : s_cnt + 1'b1;
            case (state)
                TX_IDLE: begin
                    s_cnt   <= '0;
                    bit_cnt <= '0;
                    if (i_req.start) state <= TX_START;
                end
                TX_START: if (bit_end) state <= TX_DATA;
                TX_DATA: begin
                    if (bit_end) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BIT_W'(BYTE_W - 1)) state <= TX_STOP;
                    end
                end
                TX_STOP: if (bit_end) state <= TX_IDLE;
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == TX_IDLE && i_req.start) shreg <= i_req.data;
        else if (state == TX_DATA && bit_end) shreg <= shreg >> 1;
    end

    always_comb begin
        case (state)
            TX_START: o_tx = 1'b0;
            TX_DATA:  o_tx = shreg[0];
            default:  o_tx = 1'b1;
        endcase
    end

    assign o_busy = (state != TX_IDLE);

    a_no_start_busy: assert property (@(posedge i_clk) disable iff (i_reset)
        i_req.start |-> !o_busy);

endmodule

//--- hw/uart_link.sv
`timescale 1ns/100ps

module uart_link import debug_pkg::*; (
    input  logic     i_clk,
    input  logic     i_reset,
    input  logic     i_rx,
    output logic     o_tx,
    output rx_byte_t o_rx_byte,
    input  tx_req_t  i_tx_req,
    output logic     o_tx_busy
);

    logic [TICK_W-1:0] tick_cnt;
    logic              tick;

    assign tick = (tick_cnt == TICK_W'(TICK_DIV - 1));

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) tick_cnt <= '0;
        else tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
    end

    uart_rx uart_rx_i (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_tick  (tick),
        .i_rx    (i_rx),
        .o_byte  (o_rx_byte)
    );

    uart_tx uart_tx_i (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_tick  (tick),
        .i_req   (i_tx_req),
        .o_tx    (o_tx),
        .o_busy  (o_tx_busy)
    );

endmodule

//--- hw/run_control.sv
`timescale 1ns/100ps

module run_control import debug_pkg::*; (
    input  logic     i_clk,
    input  logic     i_reset,
    input  run_cmd_t i_run_cmd,
    output logic     o_cpu_en,
    output logic     o_prog_reset,
    output logic     o_reset_done
);

    logic              step_mode;  // 0 continuous, 1 single step
    logic [STEP_W-1:0] step_cnt;
    logic [PRST_W-1:0] prst_cnt;
    logic              reset_done;

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            step_mode  <= 1'b0;
            step_cnt   <= '0;
            prst_cnt   <= '0;
            reset_done <= 1'b0;
        end else begin
            reset_done <= (prst_cnt == PRST_W'(1));  // Last reset cycle
            if (i_run_cmd.set_run) begin
                step_mode <= 1'b0;
            end else if (i_run_cmd.set_step_mode) begin
                step_mode <= 1'b1;
            end
            if (i_run_cmd.load_done) begin
                prst_cnt <= PRST_W'(PROG_RESET_CYCLES);
                step_cnt <= '0;
            end else begin
                if (prst_cnt != '0) prst_cnt <= prst_cnt - 1'b1;
                // Steps are dropped while one is running or a reset is in progress
                if (i_run_cmd.step && step_mode && prst_cnt == '0 && step_cnt == '0) begin
                    step_cnt <= STEP_W'(STEP_CYCLES);
                end else if (step_cnt != '0) begin
                    step_cnt <= step_cnt - 1'b1;
                end
            end
        end
    end

    assign o_prog_reset = (prst_cnt != '0);
    assign o_cpu_en     = step_mode ? (step_cnt != '0) : !o_prog_reset;
    assign o_reset_done = reset_done;

    a_no_run_in_reset: assert property (@(posedge i_clk) disable iff (i_reset)
        o_prog_reset |-> !o_cpu_en);

endmodule

//--- hw/program_loader.sv
`timescale 1ns/100ps

module program_loader import debug_pkg::*; (
    input  logic     i_clk,
    input  logic     i_reset,
    input  logic     i_load_active,
    input  rx_byte_t i_rx_byte,
    output imem_wr_t o_imem_wr,
    output logic     o_load_done
);

    logic              have_count;
    logic [BYTE_W-1:0] count;
    logic [BYTE_W-1:0] wcnt;  // Words written, also the write address
    logic [BIDX_W-1:0] byte_idx;
    logic              last_byte;
    logic [DATA_W-1:0] word;
    logic              wr;
    logic              done;

    assign last_byte = (byte_idx == BIDX_W'(BYTES_PER_WORD - 1));

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            have_count <= 1'b0;
            count      <= '0;
            wcnt       <= '0;
            byte_idx   <= '0;
            wr         <= 1'b0;
            done       <= 1'b0;
        end else begin
            wr   <= 1'b0;
            done <= 1'b0;
            if (!i_load_active) begin
                have_count <= 1'b0;
                wcnt       <= '0;
                byte_idx   <= '0;
            end else begin
                if (wr) begin
                    wcnt <= wcnt + 1'b1;
                    done <= (wcnt + 1'b1 == count);
                end
                if (i_rx_byte.valid && !have_count) begin
                    count      <= i_rx_byte.data;
                    have_count <= 1'b1;
                    done       <= (i_rx_byte.data == '0);  // Empty program
                end else if (i_rx_byte.valid && wcnt < count) begin
                    byte_idx <= last_byte ? '0 : byte_idx + 1'b1;
                    wr       <= last_byte;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_load_active && have_count && i_rx_byte.valid) begin
            word <= {i_rx_byte.data, word[DATA_W-1:BYTE_W]};  // LSB byte arrives first
        end
    end

    assign o_imem_wr   = '{wr: wr, addr: wcnt[IMEM_ADDR_W-1:0], data: word};
    assign o_load_done = done;

    a_addr_in_range: assert property (@(posedge i_clk) disable iff (i_reset)
        o_imem_wr.wr |-> (wcnt < IMEM_DEPTH));

endmodule

//--- hw/debug_fsm.sv
`timescale 1ns/100ps

module debug_fsm import debug_pkg::*; (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  rx_byte_t               i_rx_byte,
    output tx_req_t                o_tx_req,
    input  logic                   i_tx_busy,
    output logic                   o_load_active,
    input  logic                   i_load_done,
    output run_cmd_t               o_run_cmd,
    input  logic                   i_reset_done,
    input  logic [DATA_W-1:0]      i_pc,
    input  logic [DATA_W-1:0]      i_dmem_data,
    output logic [DMEM_ADDR_W-1:0] o_dmem_addr
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_ADDR,      // Waiting for the data memory address byte
        S_SNAP,
        S_SEND,
        S_ACK,
        S_LOAD,
        S_WAIT_RST
    } state_t;

    state_t                 state;
    logic [DATA_W-1:0]      word;
    logic [BIDX_W-1:0]      byte_cnt;
    logic [DMEM_ADDR_W-1:0] dmem_addr;
    logic                   tx_fire;

    assign tx_fire = o_tx_req.start;

    always_comb begin
        o_tx_req.start = ((state == S_SEND) || (state == S_ACK)) && !i_tx_busy;
        o_tx_req.data  = (state == S_ACK) ? ACK_BYTE : word[BYTE_W-1:0];
    end

    always_comb begin
        o_run_cmd = '0;
        if (state == S_IDLE && i_rx_byte.valid) begin
            case (i_rx_byte.data)
                CMD_LOAD, CMD_STEP_MODE: o_run_cmd.set_step_mode = 1'b1;
                CMD_RUN:                 o_run_cmd.set_run = 1'b1;
                CMD_STEP:                o_run_cmd.step = 1'b1;
                default: ;
            endcase
        end
        o_run_cmd.load_done = (state == S_LOAD) && i_load_done;
    end

    always_ff @(posedge i_clk or posedge i_reset) begin
        if (i_reset) begin
            state     <= S_IDLE;
            byte_cnt  <= '0;
            dmem_addr <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (i_rx_byte.valid) begin
                        case (i_rx_byte.data)
                            CMD_DMEM_READ: state <= S_ADDR;
                            CMD_PC_DUMP:   state <= S_SEND;
                            CMD_LOAD:      state <= S_LOAD;
                            default: ;  // Mode, step and unknown codes need no reply
                        endcase
                    end
                end
                S_ADDR: begin
                    if (i_rx_byte.valid) begin
                        dmem_addr <= i_rx_byte.data[DMEM_ADDR_W-1:0];
                        state     <= S_SNAP;
                    end
                end
                S_SNAP: state <= S_SEND;  // Address settles on the memory port
                S_SEND: begin
                    if (tx_fire) begin
                        byte_cnt <= byte_cnt + 1'b1;  // Wraps back to 0 after the word
                        if (byte_cnt == BIDX_W'(BYTES_PER_WORD - 1)) state <= S_ACK;
                    end
                end
                S_ACK:      if (tx_fire) state <= S_IDLE;
                S_LOAD:     if (i_load_done) state <= S_WAIT_RST;
                S_WAIT_RST: if (i_reset_done) state <= S_ACK;
                default:    state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == S_IDLE && i_rx_byte.valid && i_rx_byte.data == CMD_PC_DUMP) begin
            word <= i_pc;
        end else if (state == S_SNAP) begin
            word <= i_dmem_data;
        end else if (state == S_SEND && tx_fire) begin
            word <= word >> BYTE_W;  // Next byte, LSB first
        end
    end

    assign o_load_active = (state == S_LOAD);
    assign o_dmem_addr   = dmem_addr;

endmodule

//--- hw/debug_unit.sv
`timescale 1ns/100ps

module debug_unit import debug_pkg::*; (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_uart_rx,
    output logic                   o_uart_tx,
    input  logic [DATA_W-1:0]      i_pc,
    input  logic [DATA_W-1:0]      i_dmem_data,
    output logic [DMEM_ADDR_W-1:0] o_dmem_addr,
    output imem_wr_t               o_imem_wr,
    output logic                   o_cpu_en,
    output logic                   o_prog_reset
);

    rx_byte_t rx_byte;
    tx_req_t  tx_req;
    logic     tx_busy;
    logic     load_active;
    logic     load_done;
    run_cmd_t run_cmd;
    logic     reset_done;

    uart_link uart_link_i (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_rx      (i_uart_rx),
        .o_tx      (o_uart_tx),
        .o_rx_byte (rx_byte),
        .i_tx_req  (tx_req),
        .o_tx_busy (tx_busy)
    );

    debug_fsm debug_fsm_i (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_rx_byte     (rx_byte),
        .o_tx_req      (tx_req),
        .i_tx_busy     (tx_busy),
        .o_load_active (load_active),
        .i_load_done   (load_done),
        .o_run_cmd     (run_cmd),
        .i_reset_done  (reset_done),
        .i_pc          (i_pc),
        .i_dmem_data   (i_dmem_data),
        .o_dmem_addr   (o_dmem_addr)
    );

    program_loader program_loader_i (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_load_active (load_active),
        .i_rx_byte     (rx_byte),
        .o_imem_wr     (o_imem_wr),
        .o_load_done   (load_done)
    );

    run_control run_control_i (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_run_cmd    (run_cmd),
        .o_cpu_en     (o_cpu_en),
        .o_prog_reset (o_prog_reset),
        .o_reset_done (reset_done)
    );

endmodule

//--- dv/tb_debug_unit.sv
`timescale 1ns/100ps

module tb_debug_unit import debug_pkg::*; ();

    localparam int BIT_CLKS   = TICK_DIV * OVERSAMPLE;
    localparam int FRAME_CLKS = 10 * BIT_CLKS;
    localparam int GOLD_WORDS = 256;

    logic                   i_clk;
    logic                   i_reset;
    logic                   i_uart_rx;
    logic                   o_uart_tx;
    logic [DATA_W-1:0]      i_pc;
    logic [DATA_W-1:0]      i_dmem_data;
    logic [DMEM_ADDR_W-1:0] o_dmem_addr;
    imem_wr_t               o_imem_wr;
    logic                   o_cpu_en;
    logic                   o_prog_reset;

    logic [31:0]            gold [0:GOLD_WORDS-1];
    logic [BYTE_W-1:0]      reply_q [$];
    int unsigned            start_q [$];    // Cycle of each reply start bit
    logic [DMEM_ADDR_W-1:0] addr_q [$];     // o_dmem_addr seen at each start bit
    int unsigned            wr_addr_q [$];
    logic [DATA_W-1:0]      wr_data_q [$];
    int unsigned            cycle = 0;
    int unsigned            limit = 0;
    int unsigned            prst_run = 0;
    int unsigned            prst_last = 0;
    int unsigned            prst_pulses = 0;
    int unsigned            prst_fall_cyc = 0;
    int unsigned            en_run = 0;
    int unsigned            en_last = 0;
    int unsigned            en_pulses = 0;

    debug_unit debug_unit_i (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_uart_rx    (i_uart_rx),
        .o_uart_tx    (o_uart_tx),
        .i_pc         (i_pc),
        .i_dmem_data  (i_dmem_data),
        .o_dmem_addr  (o_dmem_addr),
        .o_imem_wr    (o_imem_wr),
        .o_cpu_en     (o_cpu_en),
        .o_prog_reset (o_prog_reset)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycle <= cycle + 1;
        if (cycle > limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("sim failed");
            $fatal(1, "cycle limit reached");
        end
    end

    // Pulse lengths of the program reset and the processor enable
    always @(posedge i_clk) begin
        if (o_prog_reset) begin
            prst_run <= prst_run + 1;
        end else if (prst_run != 0) begin
            prst_last     <= prst_run;
            prst_pulses   <= prst_pulses + 1;
            prst_fall_cyc <= cycle;
            prst_run      <= 0;
        end
        if (o_cpu_en) begin
            en_run <= en_run + 1;
        end else if (en_run != 0) begin
            en_last   <= en_run;
            en_pulses <= en_pulses + 1;
            en_run    <= 0;
        end
        if (!i_reset && o_imem_wr.wr) begin
            wr_addr_q.push_back(32'(o_imem_wr.addr));
            wr_data_q.push_back(o_imem_wr.data);
        end
    end

    function automatic logic [31:0] golden_word(int idx);
        return gold[idx[7:0]];
    endfunction

    task automatic compare_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("sim failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic send_byte(logic [BYTE_W-1:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};  // Stop, data LSB first, start
        for (int i = 0; i < 10; i++) begin
            @(posedge i_clk);
            i_uart_rx <= frame[0];
            frame = frame >> 1;
            repeat (BIT_CLKS - 1) @(posedge i_clk);
        end
    endtask

    task automatic receive_byte();
        logic [BYTE_W-1:0]      data;
        int unsigned            start_cyc;
        logic [DMEM_ADDR_W-1:0] addr;
        @(posedge i_clk);
        while (o_uart_tx) @(posedge i_clk);
        start_cyc = cycle;
        addr      = o_dmem_addr;
        repeat (BIT_CLKS / 2) @(posedge i_clk);  // Middle of the start bit
        compare_value("o_uart_tx start bit", 32'(o_uart_tx), 32'd0);
        for (int i = 0; i < BYTE_W; i++) begin
            repeat (BIT_CLKS) @(posedge i_clk);
            data = {o_uart_tx, data[BYTE_W-1:1]};
        end
        repeat (BIT_CLKS) @(posedge i_clk);
        compare_value("o_uart_tx stop bit", 32'(o_uart_tx), 32'd1);
        reply_q.push_back(data);
        start_q.push_back(start_cyc);
        addr_q.push_back(addr);
    endtask

    initial begin
        @(negedge i_reset);
        forever receive_byte();
    end

    initial begin
        int                     p;
        int                     nargs;
        int                     nrep;
        int                     nwr;
        int                     total;
        int                     rep_base;
        int                     wr_base;
        int                     rec;
        logic [BYTE_W-1:0]      cmd;
        logic [DMEM_ADDR_W-1:0] exp_addr;
        logic                   step_mode;
        int unsigned            prst_snap;
        int unsigned            en_snap;
        i_reset     = 1'b1;
        i_uart_rx   = 1'b1;
        i_pc        = '0;
        i_dmem_data = '0;
        exp_addr    = '0;
        step_mode   = 1'b0;
        $readmemh("dv/debug_golden.txt", gold);
        p     = 0;
        total = 0;
        while (golden_word(p) != 32'h100) begin
            nargs = golden_word(p + 1);
            nrep  = golden_word(p + 4 + nargs);
            nwr   = golden_word(p + 5 + nargs + nrep);
            total += 1 + nargs + nrep;
            p     += 6 + nargs + nrep + 2 * nwr;
        end
        if (total == 0) begin
            $display("The golden file dv/debug_golden.txt is missing or holds no records");
            $display("sim failed");
            $fatal(1, "no stimulus");
        end
        limit = total * 2 * FRAME_CLKS + 2000;

        repeat (5) @(posedge i_clk);
        i_reset <= 1'b0;
        repeat (2) @(posedge i_clk);
        compare_value("o_cpu_en", 32'(o_cpu_en), 32'd1);
        compare_value("o_prog_reset", 32'(o_prog_reset), 32'd0);
        compare_value("o_imem_wr.wr", 32'(o_imem_wr.wr), 32'd0);
        compare_value("o_uart_tx", 32'(o_uart_tx), 32'd1);
        compare_value("o_dmem_addr", 32'(o_dmem_addr), 32'd0);

        p   = 0;
        rec = 0;
        while (golden_word(p) != 32'h100) begin
            cmd   = 8'(golden_word(p));
            nargs = golden_word(p + 1);
            nrep  = golden_word(p + 4 + nargs);
            nwr   = golden_word(p + 5 + nargs + nrep);
            @(posedge i_clk);
            if (cmd == CMD_DMEM_READ) i_dmem_data <= golden_word(p + 2 + nargs);
            else i_pc <= golden_word(p + 2 + nargs);
            rep_base  = reply_q.size();
            wr_base   = wr_addr_q.size();
            prst_snap = prst_pulses;
            en_snap   = en_pulses;
            if (cmd == CMD_STEP && step_mode) begin
                compare_value("o_cpu_en before step", 32'(o_cpu_en), 32'd0);
            end
            send_byte(cmd);
            for (int i = 0; i < nargs; i++) send_byte(8'(golden_word(p + 2 + i)));
            while (reply_q.size() - rep_base < nrep) @(posedge i_clk);
            repeat (2 * FRAME_CLKS) @(posedge i_clk);  // Room for any extra reply byte
            compare_value("reply byte count", 32'(reply_q.size() - rep_base), 32'(nrep));
            for (int i = 0; i < nrep; i++) begin
                compare_value("o_uart_tx reply byte", 32'(reply_q[rep_base + i]),
                              golden_word(p + 5 + nargs + i));
            end
            compare_value("o_imem_wr count", 32'(wr_addr_q.size() - wr_base), 32'(nwr));
            for (int i = 0; i < nwr; i++) begin
                compare_value("o_imem_wr.addr", wr_addr_q[wr_base + i],
                              golden_word(p + 6 + nargs + nrep + 2 * i));
                compare_value("o_imem_wr.data", wr_data_q[wr_base + i],
                              golden_word(p + 7 + nargs + nrep + 2 * i));
            end
            case (cmd)
                CMD_LOAD, CMD_STEP_MODE: step_mode = 1'b1;
                CMD_RUN:                 step_mode = 1'b0;
                CMD_DMEM_READ:           exp_addr = DMEM_ADDR_W'(golden_word(p + 2));
                default: ;
            endcase
            if (cmd == CMD_DMEM_READ) begin
                compare_value("o_dmem_addr at reply start", 32'(addr_q[rep_base]),
                              32'(exp_addr));
            end
            if (cmd == CMD_LOAD) begin
                compare_value("o_prog_reset pulse count", prst_pulses, prst_snap + 1);
                compare_value("o_prog_reset length", prst_last, PROG_RESET_CYCLES);
                compare_value("ack after o_prog_reset falls",
                              32'(start_q[rep_base] > prst_fall_cyc), 32'd1);
            end
            if (cmd == CMD_STEP && step_mode) begin
                compare_value("o_cpu_en pulse count", en_pulses, en_snap + 1);
                compare_value("o_cpu_en step length", en_last, STEP_CYCLES);
            end
            compare_value("o_cpu_en", 32'(o_cpu_en), golden_word(p + 3 + nargs));
            compare_value("o_prog_reset", 32'(o_prog_reset), 32'd0);
            compare_value("o_dmem_addr", 32'(o_dmem_addr), 32'(exp_addr));
            p   += 6 + nargs + nrep + 2 * nwr;
            rec += 1;
        end
        $display("Ran %0d golden records", rec);
        $display("sim passed");
        $finish;
    end

endmodule

//--- dv/debug_golden.txt
// Record: cmd nargs args.. drive(i_pc or i_dmem_data) cpu_en_after nreply reply.. nwrites
// then nwrites pairs of (addr data); all hex, a single 100 ends the file
11 0 12345678 1 5 78 56 34 12 52 0
0B 1 C5 CAFEF00D 1 5 0D F0 FE CA 52 0
07 9 02 11 22 33 44 A1 B2 C3 D4 0 0 1 52 2 0 44332211 1 D4C3B2A1
0A 0 0 0 0 0
3C 0 0 0 0 0
08 0 0 1 0 0
3C 0 0 1 0 0
09 0 0 0 0 0
0A 0 0 0 0 0
08 0 0 1 0 0
07 1 00 0 0 1 52 0
0A 0 0 0 0 0
11 0 89ABCDEF 0 5 EF CD AB 89 52 0
100

//--- all.f
hw/debug_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/uart_link.sv
hw/run_control.sv
hw/program_loader.sv
hw/debug_fsm.sv
hw/debug_unit.sv
dv/tb_debug_unit.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -j 0 --top-module tb_debug_unit -f all.f -o tb_debug_unit \
    && ./obj_dir/tb_debug_unit \
    || exit 1
